// File: common/sbusPkg.sv
// The line is fixed at four words and the backplane line address at seven bits.
package sbusPkg;

  // Physical line address on the backplane.
  typedef logic [6:0] lineAdrT;

  // Word within a line.
  typedef logic [1:0] wordAdrT;

  // One request bit per word of the line. Bit n asks for word n.
  typedef logic [3:0] rqMaskT;

  localparam int WORDS_PER_LINE = 4;

  // Request as presented by the requester. It is 16 bits wide.
  typedef struct packed {
    lineAdrT lineAdr;
    wordAdrT wordAdr;
    rqMaskT  rqMask;
    logic    rd;
    logic    wr;
    logic    forceBadPar;
  } coreRqT;

  // Request as driven onto the memory bus. It is 18 bits wide.
  typedef struct packed {
    logic    startA;
    logic    startB;
    logic    rd;
    logic    wr;
    rqMaskT  rqMask;
    lineAdrT lineAdr;
    wordAdrT wordAdr;
    logic    adrPar;
  } memRqT;

  // Memory answer. Both bits are single cycle pulses.
  typedef struct packed {
    logic ackn;
    logic dataValid;
  } memRespT;

endpackage

// File: common/ctlPkg.sv
// Control types for the start logic; the bus has exactly two phases, A and B.
package ctlPkg;

  // Bus phase. It alternates every clock and is A right after reset.
  typedef enum logic {
    PHASE_A,
    PHASE_B
  } phaseT;

  // Start controller states.
  // STARTED covers the time a start A or B is on the bus.
  // RD_WAIT waits for the last read word after the start has dropped.
  typedef enum logic [1:0] {
    IDLE,
    STARTED,
    RD_WAIT
  } ctlStateT;

endpackage

// File: src/memStartCtl.sv
// One transfer at a time; lastAckn must only arrive while a start is on the bus.
`timescale 1ns/1ps

module memStartCtl (
  input  logic clk,
  input  logic rstN,
  input  logic startRq,
  input  logic isRead,
  input  logic lastAckn,
  input  logic rdDone,
  output logic load,
  output logic clear,
  output logic rdStart,
  output logic startA,
  output logic startB,
  output logic memPhaseA,
  output logic busy
);
  import ctlPkg::*;

  phaseT    phase;
  ctlStateT state;
  logic     accept;
  logic     rdHeld;
  logic     rdDoneSeen;

  assign accept    = startRq && (state == IDLE);
  assign busy      = (state != IDLE);
  assign load      = accept;
  assign rdStart   = accept && isRead;
  assign clear     = lastAckn && (state == STARTED);
  assign memPhaseA = (phase == PHASE_A);

  // The phase runs freely and is A in the first cycle out of reset.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      phase <= PHASE_A;
    end else begin
      phase <= (phase == PHASE_A) ? PHASE_B : PHASE_A;
    end
  end

  // The start goes out in the phase that follows acceptance.
  // Since the phase flips at that edge, start A is chosen while we are in B.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      startA <= 1'b0;
      startB <= 1'b0;
    end else if (accept) begin
      startA <= (phase == PHASE_B);
      startB <= (phase == PHASE_A);
    end else if (clear) begin
      startA <= 1'b0;
      startB <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state      <= IDLE;
      rdHeld     <= 1'b0;
      rdDoneSeen <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state      <= STARTED;
            rdHeld     <= isRead;
            rdDoneSeen <= 1'b0;
          end
        end
        STARTED: begin
          // Read data can all be back before the last acknowledge.
          if (rdDone) begin
            rdDoneSeen <= 1'b1;
          end
          if (lastAckn) begin
            if (!rdHeld || rdDoneSeen || rdDone) begin
              state <= IDLE;
            end else begin
              state <= RD_WAIT;
            end
          end
        end
        RD_WAIT: begin
          if (rdDone) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/rqHold.sv
// Held fields change only at load; acknowledges are consumed lowest mask bit first.
`timescale 1ns/1ps

module rqHold (
  input  logic            clk,
  input  logic            rstN,
  input  logic            load,
  input  logic            clear,
  input  sbusPkg::coreRqT coreRq,
  input  logic            ackn,
  output sbusPkg::coreRqT held,
  output logic            adrPar,
  output logic            lastAckn
);
  import sbusPkg::*;

  rqMaskT ackLeft;
  rqMaskT ackLeftLow;

  always_ff @(posedge clk) begin
    if (load) begin
      held <= coreRq;
    end
  end

  // Parity is the XOR of everything the memory decodes and flips with forceBadPar.
  assign adrPar = ^{held.lineAdr, held.wordAdr, held.rqMask, held.rd, held.wr}
                  ^ held.forceBadPar;

  // Mask with its lowest set bit removed.
  assign ackLeftLow = ackLeft & (ackLeft - rqMaskT'(1));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ackLeft <= '0;
    end else if (load) begin
      ackLeft <= coreRq.rqMask;
    end else if (clear) begin
      ackLeft <= '0;
    end else if (ackn) begin
      ackLeft <= ackLeftLow;
    end
  end

  // High on the acknowledge that takes the only bit still set.
  assign lastAckn = ackn && (ackLeft != '0) && (ackLeftLow == '0);

endmodule

// File: src/coreReadSeq.sv
// Words return in ring order from wordAdr; coreDataValid must trail rdStart by 2+ cycles.
`timescale 1ns/1ps

module coreReadSeq #(
  parameter int dataValidDelay = 2
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             rdStart,
  input  sbusPkg::rqMaskT  rqMask,
  input  sbusPkg::wordAdrT wordAdr,
  input  logic             dataValid,
  output logic             coreDataValid,
  output sbusPkg::wordAdrT coreAdr,
  output logic             coreRdInProg,
  output logic             rdDone
);
  import sbusPkg::*;

  logic [dataValidDelay-1:0] dvPipe;
  logic                      loadHeld;
  rqMaskT                    wordsLeft;
  rqMaskT                    wordBit;
  rqMaskT                    wordsAfter;
  wordAdrT                   wordCnt;

  // Returns the next requested word above cur in ring order.
  function automatic wordAdrT nextWord(rqMaskT mask, wordAdrT cur);
    wordAdrT result;
    wordAdrT probe;
    result = cur;
    for (int k = WORDS_PER_LINE - 1; k >= 1; k--) begin
      probe = cur + wordAdrT'(k);
      if (mask[probe]) begin
        result = probe;
      end
    end
    return result;
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      dvPipe <= '0;
    end else begin
      dvPipe[0] <= dataValid;
      for (int i = 1; i < dataValidDelay; i++) begin
        dvPipe[i] <= dvPipe[i-1];
      end
    end
  end

  assign coreDataValid = dvPipe[dataValidDelay-1];
  assign coreAdr       = wordCnt;
  assign wordBit       = rqMaskT'(1) << wordCnt;
  assign wordsAfter    = wordsLeft & ~wordBit;
  assign rdDone        = coreDataValid && (wordsAfter == '0);

  // The held request is only valid the cycle after rdStart, so loading waits one clock.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      loadHeld     <= 1'b0;
      coreRdInProg <= 1'b0;
      wordsLeft    <= '0;
    end else begin
      loadHeld <= rdStart;
      if (rdStart) begin
        coreRdInProg <= 1'b1;
      end else if (rdDone) begin
        coreRdInProg <= 1'b0;
      end
      if (loadHeld) begin
        wordsLeft <= rqMask;
      end else if (coreDataValid) begin
        wordsLeft <= wordsAfter;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (loadHeld) begin
      wordCnt <= wordAdr;
    end else if (coreDataValid) begin
      wordCnt <= nextWord(wordsAfter, wordCnt);
    end
  end

endmodule

// File: src/sbusCtl.sv
// Requester must hold startRq and coreRq until accepted; dataValidDelay must be 1 or more.
`timescale 1ns/1ps

module sbusCtl #(
  parameter int dataValidDelay = 2
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              startRq,
  input  sbusPkg::coreRqT   coreRq,
  output logic              busy,
  output sbusPkg::memRqT    memRq,
  input  sbusPkg::memRespT  memResp,
  output logic              memPhaseA,
  output logic              coreDataValid,
  output sbusPkg::wordAdrT  coreAdr,
  output logic              coreRdInProg
);
  import sbusPkg::*;

  logic   load;
  logic   clear;
  logic   rdStart;
  logic   startA;
  logic   startB;
  logic   lastAckn;
  logic   rdDone;
  logic   adrPar;
  coreRqT held;

  memStartCtl i_memStartCtl (
    .clk       (clk),
    .rstN      (rstN),
    .startRq   (startRq),
    .isRead    (coreRq.rd),
    .lastAckn  (lastAckn),
    .rdDone    (rdDone),
    .load      (load),
    .clear     (clear),
    .rdStart   (rdStart),
    .startA    (startA),
    .startB    (startB),
    .memPhaseA (memPhaseA),
    .busy      (busy)
  );

  rqHold i_rqHold (
    .clk      (clk),
    .rstN     (rstN),
    .load     (load),
    .clear    (clear),
    .coreRq   (coreRq),
    .ackn     (memResp.ackn),
    .held     (held),
    .adrPar   (adrPar),
    .lastAckn (lastAckn)
  );

  coreReadSeq #(
    .dataValidDelay (dataValidDelay)
  ) i_coreReadSeq (
    .clk           (clk),
    .rstN          (rstN),
    .rdStart       (rdStart),
    .rqMask        (held.rqMask),
    .wordAdr       (held.wordAdr),
    .dataValid     (memResp.dataValid),
    .coreDataValid (coreDataValid),
    .coreAdr       (coreAdr),
    .coreRdInProg  (coreRdInProg),
    .rdDone        (rdDone)
  );

  // The bus sees the held request fields next to the start bits.
  assign memRq = '{
    startA:  startA,
    startB:  startB,
    rd:      held.rd,
    wr:      held.wr,
    rqMask:  held.rqMask,
    lineAdr: held.lineAdr,
    wordAdr: held.wordAdr,
    adrPar:  adrPar
  };

endmodule

// File: sim/clkGen.sv
// Clock runs from time zero; rstN is released 1 ns after the last of the reset edges.
`timescale 1ns/1ps

module clkGen #(
  parameter int halfPeriod  = 2,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
  end

endmodule

// File: sim/tbSbusCtl.sv
// Runs 200 random transfers at dataValidDelay 2; the memory model answers only while a start is up.
`timescale 1ns/1ps

module tbSbusCtl;
  import sbusPkg::*;

  localparam int DV_DELAY       = 2;
  localparam int NUM_TRANS      = 200;
  localparam int TIMEOUT_CYCLES = NUM_TRANS * 40 + 200;

  logic    clk;
  logic    rstN;
  logic    startRq;
  coreRqT  coreRq;
  logic    busy;
  memRqT   memRq;
  memRespT memResp;
  logic    memPhaseA;
  logic    coreDataValid;
  wordAdrT coreAdr;
  logic    coreRdInProg;

  // The reference model steps once per cycle at the falling edge.
  logic                mPhaseA;
  logic                mBusy;
  logic                mStartOn;
  logic                mStartA;
  logic                mInProg;
  logic                mAckDone;
  logic                mRdFin;
  logic                mJustAccepted;
  logic                mWaited;
  logic                mHeldWaited;
  logic [DV_DELAY-1:0] dvHist;
  coreRqT              mHeld;
  int                  mAckCnt;
  int                  mAckNeed;
  wordAdrT             expOrder[$];
  bit                  firstCycle = 1'b1;
  int                  resetEdges = 0;
  int                  accepted   = 0;
  int                  waitedCnt  = 0;
  int                  badParCnt  = 0;
  int                  checkCnt[1:6] = '{default: 0};
  int                  errCnt[1:6]   = '{default: 0};

  clkGen i_clkGen (
    .clk  (clk),
    .rstN (rstN)
  );

  sbusCtl #(
    .dataValidDelay (DV_DELAY)
  ) i_sbusCtl (
    .clk           (clk),
    .rstN          (rstN),
    .startRq       (startRq),
    .coreRq        (coreRq),
    .busy          (busy),
    .memRq         (memRq),
    .memResp       (memResp),
    .memPhaseA     (memPhaseA),
    .coreDataValid (coreDataValid),
    .coreAdr       (coreAdr),
    .coreRdInProg  (coreRdInProg)
  );

  function automatic string testName(input int t);
    case (t)
      1:       return "reset";
      2:       return "start issue";
      3:       return "parity";
      4:       return "acknowledge completion";
      5:       return "read return";
      default: return "back-pressure";
    endcase
  endfunction

  task automatic checkValue(input int test, input string name,
                            input logic [31:0] expVal, input logic [31:0] actVal);
    checkCnt[test]++;
    assert (actVal === expVal) else begin
      errCnt[test]++;
      $display("mismatch at %0t ns: %s expected %0h, actual %0h", $time, name, expVal, actVal);
    end
  endtask

  task automatic reportTest(input int t);
    $display("test %0d %s done: %0d checks, %0d errors", t, testName(t), checkCnt[t], errCnt[t]);
  endtask

  task automatic checkResetLow();
    checkValue(1, "memRq.startA", 32'(0), 32'(memRq.startA));
    checkValue(1, "memRq.startB", 32'(0), 32'(memRq.startB));
    checkValue(1, "busy", 32'(0), 32'(busy));
    checkValue(1, "coreDataValid", 32'(0), 32'(coreDataValid));
    checkValue(1, "coreRdInProg", 32'(0), 32'(coreRdInProg));
  endtask

  task automatic initModel();
    mPhaseA       = 1'b1;
    mBusy         = 1'b0;
    mStartOn      = 1'b0;
    mStartA       = 1'b0;
    mInProg       = 1'b0;
    mAckDone      = 1'b1;
    mRdFin        = 1'b1;
    mJustAccepted = 1'b0;
    mWaited       = 1'b0;
    mHeldWaited   = 1'b0;
    dvHist        = '0;
    mAckCnt       = 0;
    mAckNeed      = 0;
  endtask

  task automatic modelStep();
    logic    accept;
    logic    lastAckNow;
    logic    rdDoneNow;
    logic    expPar;
    wordAdrT w;
    int      fieldTest;
    lastAckNow = 1'b0;
    rdDoneNow  = 1'b0;
    fieldTest  = mHeldWaited ? 6 : 2;
    checkValue(firstCycle ? 1 : 2, "memPhaseA", 32'(mPhaseA), 32'(memPhaseA));
    checkValue(6, "busy", 32'(mBusy), 32'(busy));
    checkValue(mJustAccepted ? 2 : 4, "memRq.startA", 32'(mStartOn && mStartA),
               32'(memRq.startA));
    checkValue(mJustAccepted ? 2 : 4, "memRq.startB", 32'(mStartOn && !mStartA),
               32'(memRq.startB));
    if (mStartOn) begin
      checkValue(fieldTest, "memRq.lineAdr", 32'(mHeld.lineAdr), 32'(memRq.lineAdr));
      checkValue(fieldTest, "memRq.wordAdr", 32'(mHeld.wordAdr), 32'(memRq.wordAdr));
      checkValue(fieldTest, "memRq.rqMask", 32'(mHeld.rqMask), 32'(memRq.rqMask));
      checkValue(fieldTest, "memRq.rd", 32'(mHeld.rd), 32'(memRq.rd));
      checkValue(fieldTest, "memRq.wr", 32'(mHeld.wr), 32'(memRq.wr));
      // Parity covers every field the memory decodes and is flipped for the diagnostic.
      expPar = ^{mHeld.lineAdr, mHeld.wordAdr, mHeld.rqMask, mHeld.rd, mHeld.wr};
      if (mHeld.forceBadPar) begin
        expPar = !expPar;
      end
      checkValue(3, "memRq.adrPar", 32'(expPar), 32'(memRq.adrPar));
      if (memResp.ackn) begin
        mAckCnt++;
        lastAckNow = (mAckCnt == mAckNeed);
      end
    end
    checkValue(5, "coreRdInProg", 32'(mInProg), 32'(coreRdInProg));
    checkValue(5, "coreDataValid", 32'(dvHist[DV_DELAY-1]), 32'(coreDataValid));
    if (dvHist[DV_DELAY-1]) begin
      assert (expOrder.size() > 0) else begin
        errCnt[5]++;
        $display("error at %0t ns: coreDataValid came with no read word outstanding", $time);
      end
      if (expOrder.size() > 0) begin
        w = expOrder.pop_front();
        checkValue(5, "coreAdr", 32'(w), 32'(coreAdr));
        rdDoneNow = (expOrder.size() == 0);
      end
    end
    dvHist = {dvHist[DV_DELAY-2:0], memResp.dataValid};

    accept = startRq && !mBusy;
    if (startRq && mBusy) begin
      mWaited = 1'b1;
    end
    mJustAccepted = accept;
    if (accept) begin
      mHeld       = coreRq;
      mHeldWaited = mWaited;
      mWaited     = 1'b0;
      mStartOn    = 1'b1;
      mStartA     = !mPhaseA;
      mBusy       = 1'b1;
      mAckCnt     = 0;
      mAckNeed    = $countones(coreRq.rqMask);
      mAckDone    = 1'b0;
      mRdFin      = !coreRq.rd;
      mInProg     = coreRq.rd;
      accepted++;
      if (mHeldWaited) begin
        waitedCnt++;
      end
      if (coreRq.forceBadPar) begin
        badParCnt++;
      end
      // Words come back upward from the start word, wrapping around the line.
      if (coreRq.rd) begin
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
          w = coreRq.wordAdr + wordAdrT'(k);
          if (coreRq.rqMask[w]) begin
            expOrder.push_back(w);
          end
        end
      end
    end
    if (lastAckNow) begin
      mStartOn = 1'b0;
      mAckDone = 1'b1;
    end
    if (rdDoneNow) begin
      mInProg = 1'b0;
      mRdFin  = 1'b1;
    end
    if (mBusy && !accept && mAckDone && mRdFin) begin
      mBusy = 1'b0;
    end
    mPhaseA = !mPhaseA;
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      resetEdges++;
    end
  end

  always @(negedge clk) begin
    if (!rstN) begin
      if (resetEdges > 0) begin
        checkResetLow();
      end
    end else begin
      if (firstCycle) begin
        initModel();
        checkResetLow();
      end
      modelStep();
      if (firstCycle) begin
        reportTest(1);
        firstCycle = 1'b0;
      end
    end
  end

  function automatic coreRqT randomRequest();
    coreRqT rq;
    rq.lineAdr     = lineAdrT'($urandom);
    rq.wordAdr     = wordAdrT'($urandom_range(0, 3));
    rq.rqMask      = rqMaskT'($urandom) | (rqMaskT'(1) << rq.wordAdr);
    rq.rd          = ($urandom_range(0, 1) == 1);
    rq.wr          = !rq.rd;
    rq.forceBadPar = ($urandom_range(0, 7) == 0);
    return rq;
  endfunction

  task automatic waitNotBusy();
    logic idle;
    idle = 1'b0;
    while (!idle) begin
      @(negedge clk);
      idle = !busy;
    end
  endtask

  task automatic finishRun();
    int totalChecks;
    int totalErrs;
    totalChecks = 0;
    totalErrs   = 0;
    checkValue(6, "accepted count", 32'(NUM_TRANS), 32'(accepted));
    checkValue(5, "read words outstanding", 32'(0), 32'(expOrder.size()));
    for (int t = 2; t <= 6; t++) begin
      reportTest(t);
    end
    for (int t = 1; t <= 6; t++) begin
      totalChecks += checkCnt[t];
      totalErrs   += errCnt[t];
    end
    $display("%0d checks, %0d errors, %0d transfers, %0d held off by busy, %0d bad parity",
             totalChecks, totalErrs, accepted, waitedCnt, badParCnt);
    if (totalErrs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // Requester. A zero gap puts the next request up while the DUT is still busy.
  initial begin : stimulus
    int gap;
    startRq = 1'b0;
    coreRq  = '0;
    void'($urandom(32'hed99_fb43));
    @(posedge rstN);
    @(posedge clk);
    #1;
    for (int t = 0; t < NUM_TRANS; t++) begin
      coreRq  = randomRequest();
      startRq = 1'b1;
      waitNotBusy();
      @(posedge clk);
      #1;
      gap = $urandom_range(0, 5);
      if (gap > 0) begin
        startRq = 1'b0;
        repeat (gap) @(posedge clk);
        #1;
      end
    end
    startRq = 1'b0;
    waitNotBusy();
    repeat (4) @(posedge clk);
    finishRun();
  end

  // Memory side. Read data starts no earlier than the cycle after the first ackn.
  initial begin : memResponder
    int acksLeft;
    int dvLeft;
    int acknGap;
    int dvGap;
    bit active;
    bit acknSeen;
    memResp  = '0;
    active   = 1'b0;
    acknSeen = 1'b0;
    acksLeft = 0;
    dvLeft   = 0;
    acknGap  = 0;
    dvGap    = 0;
    @(posedge rstN);
    forever begin
      @(posedge clk);
      #1;
      memResp = '0;
      if (!active && (memRq.startA || memRq.startB)) begin
        active   = 1'b1;
        acknSeen = 1'b0;
        acksLeft = $countones(memRq.rqMask);
        dvLeft   = memRq.rd ? acksLeft : 0;
        acknGap  = $urandom_range(0, 3);
        dvGap    = $urandom_range(0, 3);
      end
      if (active) begin
        if (dvLeft > 0 && acknSeen) begin
          if (dvGap == 0) begin
            memResp.dataValid = 1'b1;
            dvLeft--;
            dvGap = $urandom_range(0, 3);
          end else begin
            dvGap--;
          end
        end
        if (acksLeft > 0) begin
          if (acknGap == 0) begin
            memResp.ackn = 1'b1;
            acksLeft--;
            acknSeen = 1'b1;
            acknGap  = $urandom_range(0, 3);
          end else begin
            acknGap--;
          end
        end
        if (acksLeft == 0 && dvLeft == 0) begin
          active = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: sources.f
common/sbusPkg.sv
common/ctlPkg.sv
src/memStartCtl.sv
src/rqHold.sv
src/coreReadSeq.sv
src/sbusCtl.sv
sim/clkGen.sv
sim/tbSbusCtl.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbSbusCtl -f sources.f -o simSbusCtl &&
./obj_dir/simSbusCtl | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation failed or did not build"; exit 1; }
